//--- Bender.yml
package:
  name: i3c_enthdr

sources:
  - common/i3c_pkg.sv
  - hw/i3c_scl_gen.sv
  - hw/regf/i3c_regf.sv
  - hw/i3c_sdr_tx.sv
  - hw/i3c_sdr_rx.sv
  - hw/enthdr/i3c_enthdr_fsm.sv
  - hw/i3c_enthdr_top.sv
  - target: test
    files:
      - tests/i3c_enthdr_chk.sv
      - tests/i3c_enthdr_tb.sv

//--- common/i3c_pkg.sv
/* i3c controller shared definitions
   register map, serializer and receiver modes, control and status words */
`default_nettype none

package i3c_pkg;

  // register file map
  localparam int REGF_AW = 12;                                 // address width
  localparam logic [REGF_AW-1:0] REGF_BCAST_ADDR = 12'd46;     // 7'h7e + write bit
  localparam logic [REGF_AW-1:0] REGF_CCC_ADDR   = 12'd50;     // enthdr ccc code

  // what the sda serializer does in the current phase
  typedef enum logic [2:0] {
    TX_START   = 3'd0,  // sda falls while scl high
    TX_BYTE    = 3'd1,  // 8 bits msb first
    TX_TBIT    = 3'd2,  // odd parity of last byte
    TX_STOP    = 3'd3,  // sda rises while scl high
    TX_RELEASE = 3'd4   // hands sda to the target for ack
  } i3c_tx_mode_e;

  // receiver sampling modes
  typedef enum logic [1:0] {
    RX_ACK = 2'd0,      // ack bit, reports nack and done
    RX_ARB = 2'd1       // header bits, sample only
  } i3c_rx_mode_e;

  // engine to serializer, held for a whole phase
  typedef struct packed {
    logic         en;     // phase active
    i3c_tx_mode_e mode;
    logic         pp_od;  // 1 push-pull, 0 open-drain
  } i3c_tx_ctrl_t;

  // completion status returned with done
  typedef struct packed {
    logic nack;           // target did not ack the broadcast header
  } i3c_status_t;

  // request attributes
  typedef struct packed {
    logic stop_after_nack;  // end the frame with stop on nack
  } i3c_req_t;

endpackage

`default_nettype wire

//--- hw/enthdr/i3c_enthdr_fsm.sv
/* enthdr command engine
   sequences start, broadcast header, ack, ccc code, t bit and stop and
   reports done with the nack status */
`timescale 1ns/1ps
`default_nettype none

module i3c_enthdr_fsm (
  input  wire                         i_clk,
  input  wire                         i_rst_n,
  input  wire                         i_req_valid,
  output logic                        o_req_ready,
  output logic                        o_done_valid,
  output i3c_pkg::i3c_status_t        o_done_status,
  input  wire                         i_tx_mode_done,
  input  wire                         i_rx_mode_done,
  input  wire                         i_rx_nack,
  input  wire                         i_scl_fall,
  output i3c_pkg::i3c_tx_ctrl_t       o_tx_ctrl,
  output logic                        o_rx_en,
  output i3c_pkg::i3c_rx_mode_e       o_rx_mode,
  output logic                        o_regf_rd_en,
  output logic [i3c_pkg::REGF_AW-1:0] o_regf_addr,
  output logic                        o_bus_active
);

  import i3c_pkg::*;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    START     = 3'd1,
    BROADCAST = 3'd2,
    ACK       = 3'd3,
    CCC       = 3'd4,
    TBIT      = 3'd5,
    STOP      = 3'd6
  } state_e;

  state_e state;
  logic   nack_q;                    // header was not acked
  logic   tx_step;                   // serializer phase ends on this scl fall
  logic   ack_step;

  assign tx_step  = i_tx_mode_done && i_scl_fall;
  assign ack_step = i_rx_mode_done && i_scl_fall;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state        <= IDLE;
      nack_q       <= 1'b0;
      o_done_valid <= 1'b0;
    end
    else
    begin
      o_done_valid <= 1'b0;
      case (state)
        IDLE:
        begin
          if (i_req_valid && o_req_ready)
          begin
            state  <= START;
            nack_q <= 1'b0;
          end
        end
        START:     if (tx_step) state <= BROADCAST;
        BROADCAST: if (tx_step) state <= ACK;
        ACK:
        begin
          if (ack_step)
          begin
            nack_q <= i_rx_nack;
            state  <= i_rx_nack ? STOP : CCC;   // nack skips the ccc byte
          end
        end
        CCC:       if (tx_step) state <= TBIT;
        TBIT:      if (tx_step) state <= STOP;
        STOP:
        begin
          if (i_tx_mode_done)        // sda released with scl parked high
          begin
            state        <= IDLE;
            o_done_valid <= 1'b1;
          end
        end
        default:   state <= IDLE;
      endcase
    end
  end

  assign o_req_ready         = (state == IDLE) && !o_done_valid;
  assign o_done_status.nack  = nack_q;
  assign o_bus_active        = (state != IDLE) && (state != STOP);  // stop lets scl park
  assign o_regf_rd_en        = (state == IDLE) || (state == ACK);   // one phase ahead
  assign o_regf_addr         = (state == ACK) ? REGF_CCC_ADDR : REGF_BCAST_ADDR;
  assign o_rx_en             = (state == BROADCAST) || (state == ACK);
  assign o_rx_mode           = (state == ACK) ? RX_ACK : RX_ARB;

  always_comb
  begin
    o_tx_ctrl.en    = (state != IDLE);
    o_tx_ctrl.mode  = TX_RELEASE;    // ack slot and idle
    o_tx_ctrl.pp_od = 1'b0;          // open-drain unless the ccc part
    case (state)
      START:     o_tx_ctrl.mode = TX_START;
      BROADCAST: o_tx_ctrl.mode = TX_BYTE;
      CCC:
      begin
        o_tx_ctrl.mode  = TX_BYTE;
        o_tx_ctrl.pp_od = 1'b1;
      end
      TBIT:
      begin
        o_tx_ctrl.mode  = TX_TBIT;
        o_tx_ctrl.pp_od = 1'b1;
      end
      STOP:      o_tx_ctrl.mode = TX_STOP;
      default:   o_tx_ctrl.mode = TX_RELEASE;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/i3c_enthdr_top.sv
/* enthdr controller slice
   engine, scl generator, sda serializer, receiver and register file */
`timescale 1ns/1ps
`default_nettype none

module i3c_enthdr_top #(
  parameter int CLK_DIV = 4                       // clocks per scl half period
) (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire                        i_req_valid,
  input  wire i3c_pkg::i3c_req_t     i_req,
  output logic                       o_req_ready,
  output logic                       o_done_valid,
  output i3c_pkg::i3c_status_t       o_done_status,
  input  wire                        i_cfg_we,
  input  wire [i3c_pkg::REGF_AW-1:0] i_cfg_addr,
  input  wire [7:0]                  i_cfg_wdata,
  output logic                       o_scl,
  output logic                       o_sda_drive_low,
  output logic                       o_pp_od,
  input  wire                        i_sda
);

  import i3c_pkg::*;

  i3c_tx_ctrl_t       tx_ctrl;
  logic               tx_mode_done;
  logic               rx_en;
  i3c_rx_mode_e       rx_mode;
  logic               rx_mode_done;
  logic               rx_nack;
  logic               regf_rd_en;
  logic [REGF_AW-1:0] regf_addr;
  logic [7:0]         regf_rdata;
  logic               bus_active;
  logic               scl_rise;
  logic               scl_fall;
  logic               req_valid;

  // only the stop-after-nack policy exists in this engine
  assign req_valid = i_req_valid && i_req.stop_after_nack;

  i3c_enthdr_fsm u_fsm (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_req_valid    (req_valid),
    .o_req_ready    (o_req_ready),
    .o_done_valid   (o_done_valid),
    .o_done_status  (o_done_status),
    .i_tx_mode_done (tx_mode_done),
    .i_rx_mode_done (rx_mode_done),
    .i_rx_nack      (rx_nack),
    .i_scl_fall     (scl_fall),
    .o_tx_ctrl      (tx_ctrl),
    .o_rx_en        (rx_en),
    .o_rx_mode      (rx_mode),
    .o_regf_rd_en   (regf_rd_en),
    .o_regf_addr    (regf_addr),
    .o_bus_active   (bus_active)
  );

  i3c_scl_gen #(.CLK_DIV(CLK_DIV)) u_scl_gen (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_en       (bus_active),
    .o_scl      (o_scl),
    .o_scl_rise (scl_rise),
    .o_scl_fall (scl_fall)
  );

  i3c_sdr_tx u_sdr_tx (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_ctrl          (tx_ctrl),
    .i_data          (regf_rdata),
    .i_scl_rise      (scl_rise),
    .i_scl_fall      (scl_fall),
    .o_sda_drive_low (o_sda_drive_low),
    .o_pp_od         (o_pp_od),
    .o_mode_done     (tx_mode_done)
  );

  i3c_sdr_rx u_sdr_rx (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_en        (rx_en),
    .i_mode      (rx_mode),
    .i_sda       (i_sda),
    .i_scl_rise  (scl_rise),
    .i_scl_fall  (scl_fall),
    .o_nack      (rx_nack),
    .o_mode_done (rx_mode_done)
  );

  i3c_regf u_regf (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_we    (i_cfg_we),
    .i_waddr (i_cfg_addr),
    .i_wdata (i_cfg_wdata),
    .i_rd_en (regf_rd_en),
    .i_raddr (regf_addr),
    .o_rdata (regf_rdata)
  );

endmodule

`default_nettype wire

//--- hw/i3c_scl_gen.sv
/* scl generator
   toggles scl every CLK_DIV clocks while enabled and flags the edges one
   cycle ahead, parks high once released */
`timescale 1ns/1ps
`default_nettype none

module i3c_scl_gen #(
  parameter int CLK_DIV = 4          // i_clk cycles per scl half period, >= 2
) (
  input  wire  i_clk,
  input  wire  i_rst_n,
  input  wire  i_en,
  output logic o_scl,
  output logic o_scl_rise,           // scl goes high at the next clock edge
  output logic o_scl_fall            // scl goes low at the next clock edge
);

  localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [CW-1:0] CNT_MAX = CW'(CLK_DIV - 1);

  logic [CW-1:0] cnt;                // position inside the half period
  logic          run;
  logic          last;               // final cycle of the half period

  assign run  = i_en || !o_scl;      // a low phase is always finished so scl parks high
  assign last = (cnt == CNT_MAX);

  assign o_scl_rise = run && last && !o_scl;
  assign o_scl_fall = i_en && last && o_scl;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      cnt   <= '0;
      o_scl <= 1'b1;                 // idle bus
    end
    else if (run)
    begin
      if (last)
      begin
        cnt   <= '0;
        o_scl <= ~o_scl;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
    else
    begin
      cnt <= '0;                     // next frame starts with a full high phase
    end
  end

endmodule

`default_nettype wire

//--- hw/i3c_sdr_rx.sv
/* sdr receiver
   samples sda on scl rise, reports ack or nack at the following scl fall */
`timescale 1ns/1ps
`default_nettype none

module i3c_sdr_rx (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire                        i_en,
  input  wire i3c_pkg::i3c_rx_mode_e i_mode,
  input  wire                        i_sda,
  input  wire                        i_scl_rise,
  input  wire                        i_scl_fall,
  output logic                       o_nack,
  output logic                       o_mode_done
);

  import i3c_pkg::*;

  logic sda_q;                       // last sampled bus level
  logic ack_seen;                    // ack bit captured in this phase
  logic ack_mode;

  assign ack_mode = (i_mode == RX_ACK);

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      sda_q    <= 1'b0;
      ack_seen <= 1'b0;
    end
    else if (!i_en)
    begin
      ack_seen <= 1'b0;
    end
    else if (i_scl_rise)
    begin
      sda_q    <= i_sda;             // header bits in arb mode are only sampled
      ack_seen <= ack_mode;
    end
  end

  assign o_nack      = sda_q;        // high level means nobody pulled sda low
  assign o_mode_done = i_en && ack_mode && ack_seen && i_scl_fall;

endmodule

`default_nettype wire

//--- hw/i3c_sdr_tx.sv
/* sdr sda serializer
   start, byte, t bit and stop on the sda line, with its own bit counter
   and odd parity */
`timescale 1ns/1ps
`default_nettype none

module i3c_sdr_tx (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire i3c_pkg::i3c_tx_ctrl_t i_ctrl,
  input  wire [7:0]                  i_data,
  input  wire                        i_scl_rise,
  input  wire                        i_scl_fall,
  output logic                       o_sda_drive_low,
  output logic                       o_pp_od,
  output logic                       o_mode_done
);

  import i3c_pkg::*;

  logic         prev_en;             // ctrl as seen last cycle
  i3c_tx_mode_e prev_mode;
  logic         phase_start;         // first cycle of a new phase
  logic         shift;               // next data bit goes out
  logic [7:0]   shreg;
  logic [2:0]   bit_cnt;             // bits already on the line minus one
  logic         tbit;                // odd parity of last loaded byte
  logic         stop_hi;             // scl is high during stop

  assign phase_start = i_ctrl.en && (!prev_en || (prev_mode != i_ctrl.mode));
  assign shift = i_ctrl.en && (i_ctrl.mode == TX_BYTE) && i_scl_fall &&
                 (bit_cnt != 3'd7) && !phase_start;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      prev_en         <= 1'b0;
      prev_mode       <= TX_START;
      o_sda_drive_low <= 1'b0;
      o_pp_od         <= 1'b0;       // open-drain at idle
      bit_cnt         <= 3'd0;
      stop_hi         <= 1'b0;
    end
    else
    begin
      prev_en   <= i_ctrl.en;
      prev_mode <= i_ctrl.mode;
      o_pp_od   <= i_ctrl.en && i_ctrl.pp_od;  // follows the phase, aligned with sda
      if (!i_ctrl.en)
      begin
        o_sda_drive_low <= 1'b0;     // released between frames
        stop_hi         <= 1'b0;
      end
      else if (phase_start)
      begin
        bit_cnt <= 3'd0;
        stop_hi <= 1'b0;
        case (i_ctrl.mode)
          TX_START: o_sda_drive_low <= 1'b1;          // scl still high here
          TX_BYTE:  o_sda_drive_low <= ~i_data[7];     // msb first
          TX_TBIT:  o_sda_drive_low <= ~tbit;
          TX_STOP:  o_sda_drive_low <= 1'b1;          // low before scl rises
          default:  o_sda_drive_low <= 1'b0;          // ack slot, target drives
        endcase
      end
      else if (shift)
      begin
        bit_cnt         <= bit_cnt + 3'd1;
        o_sda_drive_low <= ~shreg[6];
      end
      else if (i_ctrl.mode == TX_STOP)
      begin
        if (stop_hi)
          o_sda_drive_low <= 1'b0;   // sda rises with scl high
        if (i_scl_rise)
          stop_hi <= 1'b1;
      end
    end
  end

  // byte payload and its parity
  always_ff @(posedge i_clk)
  begin
    if (phase_start && (i_ctrl.mode == TX_BYTE))
    begin
      shreg <= i_data;
      tbit  <= ~^i_data;             // odd parity over data plus t
    end
    else if (shift)
    begin
      shreg <= {shreg[6:0], 1'b0};
    end
  end

  always_comb
  begin
    o_mode_done = 1'b0;
    if (i_ctrl.en)
    begin
      case (i_ctrl.mode)
        TX_BYTE: o_mode_done = i_scl_fall && (bit_cnt == 3'd7);
        TX_STOP: o_mode_done = stop_hi;                 // no more scl edges once parked
        default: o_mode_done = i_scl_fall;              // single bit phases
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/regf/i3c_regf.sv
/* controller register file
   holds the broadcast header and the ccc code, config write port and a
   registered read port */
`timescale 1ns/1ps
`default_nettype none

module i3c_regf (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire                        i_we,
  input  wire [i3c_pkg::REGF_AW-1:0] i_waddr,
  input  wire [7:0]                  i_wdata,
  input  wire                        i_rd_en,
  input  wire [i3c_pkg::REGF_AW-1:0] i_raddr,
  output logic [7:0]                 o_rdata
);

  import i3c_pkg::*;

  localparam int NREG = REGF_CCC_ADDR - REGF_BCAST_ADDR + 1;  // 46..50
  localparam int IW   = $clog2(NREG);
  localparam logic [7:0] BCAST_RST = 8'hFC;                   // 7'h7e, write
  localparam logic [7:0] CCC_RST   = 8'h20;                   // enthdr0

  logic [7:0]    mem [NREG];
  logic          w_hit;
  logic          r_hit;
  logic [IW-1:0] widx;
  logic [IW-1:0] ridx;

  assign w_hit = (i_waddr >= REGF_BCAST_ADDR) && (i_waddr <= REGF_CCC_ADDR);
  assign r_hit = (i_raddr >= REGF_BCAST_ADDR) && (i_raddr <= REGF_CCC_ADDR);
  assign widx  = IW'(i_waddr - REGF_BCAST_ADDR);
  assign ridx  = IW'(i_raddr - REGF_BCAST_ADDR);

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < NREG; i++)
      begin
        mem[i] <= (i == 0) ? BCAST_RST : (i == NREG - 1) ? CCC_RST : 8'h00;
      end
    end
    else if (i_we && w_hit)
    begin
      mem[widx] <= i_wdata;          // writes outside the window are dropped
    end
  end

  // read data lands one cycle after the request and holds otherwise
  always_ff @(posedge i_clk)
  begin
    if (i_rd_en)
    begin
      o_rdata <= r_hit ? mem[ridx] : 8'h00;
    end
  end

endmodule

`default_nettype wire

//--- i3c_enthdr_top.f
common/i3c_pkg.sv
hw/i3c_scl_gen.sv
hw/regf/i3c_regf.sv
hw/i3c_sdr_tx.sv
hw/i3c_sdr_rx.sv
hw/enthdr/i3c_enthdr_fsm.sv
hw/i3c_enthdr_top.sv
tests/i3c_enthdr_chk.sv
tests/i3c_enthdr_tb.sv

//--- tests/i3c_enthdr_chk.sv
/* enthdr bus and handshake assertions
   bound into the controller top level */
`timescale 1ns/1ps
`default_nettype none

module i3c_enthdr_chk (
  input wire                        i_clk,
  input wire                        i_rst_n,
  input wire                        i_req_valid,
  input wire                        i_req_ready,
  input wire                        i_done_valid,
  input wire                        i_scl,
  input wire                        i_sda_drive_low,
  input wire i3c_pkg::i3c_tx_mode_e i_tx_mode
);

  import i3c_pkg::*;

  int fails = 0;                     // number of failed assertions

  // with scl high only start (sda falls) or stop (sda rises) move sda
  sda_scl_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_scl && $past(i_scl) && $changed(i_sda_drive_low)) |->
      ((i_sda_drive_low && ($past(i_tx_mode) == TX_START)) ||
       (!i_sda_drive_low && ($past(i_tx_mode) == TX_STOP))))
  else
  begin
    $error("sda moved with scl high outside start or stop");
    fails++;
  end

  done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_done_valid |=> !i_done_valid)
  else
  begin
    $error("done pulse longer than one cycle");
    fails++;
  end

  busy_after_accept: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_req_valid && i_req_ready) |=> !i_req_ready)
  else
  begin
    $error("ready stayed high after an accepted request");
    fails++;
  end

  ready_after_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_req_ready) |-> $past(i_done_valid))
  else
  begin
    $error("ready rose without a done pulse before it");
    fails++;
  end

endmodule

bind i3c_enthdr_top i3c_enthdr_chk u_chk (
  .i_clk           (i_clk),
  .i_rst_n         (i_rst_n),
  .i_req_valid     (req_valid),
  .i_req_ready     (o_req_ready),
  .i_done_valid    (o_done_valid),
  .i_scl           (o_scl),
  .i_sda_drive_low (o_sda_drive_low),
  .i_tx_mode       (tx_ctrl.mode)
);

`default_nettype wire

//--- tests/i3c_enthdr_patterns.txt
# ccc(hex) resp tbit nack
# resp is the sda level the target leaves in the ack slot, 0 acks and 1 nacks
20 0 0 0
21 0 1 0
22 0 1 0
23 0 0 0
20 1 0 1
23 1 0 1
22 0 1 0
21 1 1 1
21 0 1 0
20 0 0 0

//--- tests/i3c_enthdr_tb.sv
/* enthdr controller testbench
   pattern driven frames with a target model and an scl/sda decoder */
`timescale 1ns/1ps
`default_nettype none

module i3c_enthdr_tb;

  import i3c_pkg::*;

  localparam int CLK_DIV = 4;                     // clocks per scl half period
  localparam int HALF    = 50;                    // 100 ns clock

  logic               i_clk;
  logic               i_rst_n;
  logic               i_req_valid;
  i3c_req_t           i_req;
  logic               o_req_ready;
  logic               o_done_valid;
  i3c_status_t        o_done_status;
  logic               i_cfg_we;
  logic [REGF_AW-1:0] i_cfg_addr;
  logic [7:0]         i_cfg_wdata;
  logic               o_scl;
  logic               o_sda_drive_low;
  logic               o_pp_od;
  wire                i_sda;

  logic [7:0]  pat_ccc [$];                       // pattern columns
  logic        pat_resp [$];
  logic        pat_tbit [$];
  logic        pat_nack [$];
  logic        target_low;                        // target pulls sda in the ack slot
  logic        ack_level;                         // ack slot level where 0 means ack
  logic        prev_scl;
  logic        prev_sda;
  logic        in_frame;
  logic        stop_seen;
  logic [31:0] bit_val;                           // sda at each scl rise since start
  logic [31:0] bit_pp;                            // o_pp_od at each scl rise
  int          nbits;
  int          errors;
  int          accepts;
  int          dones;
  int          cycles;
  int          limit_cycles;
  integer      seed;
  string       test_name;

  // sda pulled up unless the controller or the target pulls it low
  assign i_sda = !(o_sda_drive_low || target_low);

  i3c_enthdr_top #(.CLK_DIV(CLK_DIV)) UUT (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_req_valid     (i_req_valid),
    .i_req           (i_req),
    .o_req_ready     (o_req_ready),
    .o_done_valid    (o_done_valid),
    .o_done_status   (o_done_status),
    .i_cfg_we        (i_cfg_we),
    .i_cfg_addr      (i_cfg_addr),
    .i_cfg_wdata     (i_cfg_wdata),
    .o_scl           (o_scl),
    .o_sda_drive_low (o_sda_drive_low),
    .o_pp_od         (o_pp_od),
    .i_sda           (i_sda)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #HALF i_clk = ~i_clk;
  end

  task automatic finish_run();
    $display("tests %0d, accepted %0d, done pulses %0d, errors %0d",
             pat_ccc.size(), accepts, dones, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("** Error: %s: %s expected %0h, actual %0h", test_name, what, exp, act);
  endtask

  function automatic logic [7:0] assemble_byte(input int first);
    logic [7:0] b;
    for (int i = 0; i < 8; i++)
      b[7-i] = bit_val[first + i];                // msb first on the wire
    return b;
  endfunction

  always @(posedge i_clk)
  begin
    cycles++;
    if (cycles > limit_cycles)
    begin
      $display("timeout, the run did not end within %0d cycles", limit_cycles);
      errors++;
      finish_run();
    end
  end

  always @(negedge i_clk)
    if (o_done_valid === 1'b1)
      dones++;                                    // a stretched pulse counts once per cycle

  // decode the bus and play the target in the ack slot
  always @(negedge i_clk)
  begin : bus_decode
    logic sda_now;
    sda_now = i_sda;
    if (o_scl && prev_scl && prev_sda && !sda_now)
    begin
      in_frame  = 1'b1;                           // start
      stop_seen = 1'b0;
      nbits     = 0;
      bit_val   = '0;
      bit_pp    = '0;
    end
    else if (in_frame && o_scl && prev_scl && !prev_sda && sda_now)
    begin
      in_frame  = 1'b0;                           // stop
      stop_seen = 1'b1;
    end
    else if (in_frame && o_scl && !prev_scl && (nbits < 32))
    begin
      bit_val[nbits] = sda_now;
      bit_pp[nbits]  = o_pp_od;
      nbits++;
    end
    if (in_frame && !o_scl && prev_scl)
      target_low = (nbits == 8) && !ack_level;    // ack slot follows the 8th header bit
    prev_scl = o_scl;
    prev_sda = sda_now;
  end

  task automatic run_test(input int idx);
    logic [7:0]  code;
    logic        resp;
    logic        exp_t;
    logic        exp_nack;
    int          data_bits;
    int          gap;
    i3c_status_t status;
    code      = pat_ccc[idx];
    resp      = pat_resp[idx];
    exp_t     = pat_tbit[idx];
    exp_nack  = pat_nack[idx];
    test_name = $sformatf("test %0d ccc %02h %s", idx, code, resp ? "nack" : "ack");
    gap = ($random(seed) & 7) + 1;
    repeat (gap) @(negedge i_clk);
    i_cfg_we    = 1'b1;                           // new ccc code between frames
    i_cfg_addr  = REGF_CCC_ADDR;
    i_cfg_wdata = code;
    @(negedge i_clk);
    i_cfg_we    = 1'b0;
    ack_level   = resp;
    i_req_valid = 1'b1;                           // held high through the frame
    while (!o_req_ready)
      @(negedge i_clk);
    accepts++;
    @(negedge i_clk);
    while (!o_done_valid)
    begin
      if (o_req_ready)
      begin
        errors++;
        $display("%s: ready went high while the frame was still running", test_name);
      end
      @(negedge i_clk);
    end
    status      = o_done_status;
    i_req_valid = 1'b0;
    @(negedge i_clk);
    if (o_req_ready !== 1'b1)
      report_mismatch("ready after done", 1, o_req_ready);
    if (!stop_seen)
    begin
      errors++;
      $display("%s: no stop condition seen on the bus", test_name);
    end
    data_bits = nbits - 1;                        // the last rise belongs to the stop
    if (assemble_byte(0) !== 8'hFC)
      report_mismatch("header byte", 8'hFC, assemble_byte(0));
    if (bit_pp[8:0] !== 9'h000)
      report_mismatch("pp_od over header and ack", 9'h000, bit_pp[8:0]);
    if (bit_val[8] !== resp)
      report_mismatch("ack slot level", resp, bit_val[8]);
    if (status.nack !== exp_nack)
      report_mismatch("done status nack", exp_nack, status.nack);
    if (exp_t !== ~^code)
      report_mismatch("pattern t bit against odd parity", ~^code, exp_t);
    if (!resp)
    begin
      if (data_bits != 18)
        report_mismatch("bits before stop", 18, data_bits);
      if (assemble_byte(9) !== code)
        report_mismatch("ccc byte", code, assemble_byte(9));
      if (bit_pp[17:9] !== 9'h1FF)
        report_mismatch("pp_od over ccc and t bit", 9'h1FF, bit_pp[17:9]);
      if (bit_val[17] !== exp_t)
        report_mismatch("t bit", exp_t, bit_val[17]);
    end
    else if (data_bits != 9)
      report_mismatch("bits before stop", 9, data_bits);
  endtask

  initial
  begin
    integer     fd;
    integer     rc;
    string      line;
    logic [7:0] c;
    int         r;
    int         t;
    int         k;
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '{stop_after_nack: 1'b1};
    i_cfg_we    = 1'b0;
    i_cfg_addr  = '0;
    i_cfg_wdata = 8'h00;
    target_low  = 1'b0;
    ack_level   = 1'b1;
    prev_scl    = 1'b1;
    prev_sda    = 1'b1;
    in_frame    = 1'b0;
    stop_seen   = 1'b0;
    seed        = 32'hd063;
    fd = $fopen("tests/i3c_enthdr_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the pattern file tests/i3c_enthdr_patterns.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        if ((rc > 0) && (line.getc(0) != "#"))
        begin
          if ($sscanf(line, "%h %d %d %d", c, r, t, k) == 4)
          begin
            pat_ccc.push_back(c);
            pat_resp.push_back(r[0]);
            pat_tbit.push_back(t[0]);
            pat_nack.push_back(k[0]);
          end
        end
      end
      $fclose(fd);
      if (pat_ccc.size() == 0)
      begin
        $display("the pattern file holds no tests");
        errors++;
      end
    end
    limit_cycles = (pat_ccc.size() + 1) * (20 * 2 * CLK_DIV + 40);  // one slot for reset
    repeat (10) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    test_name = "after reset";
    if (o_req_ready !== 1'b1)
      report_mismatch("req ready", 1, o_req_ready);
    if (o_done_valid !== 1'b0)
      report_mismatch("done valid", 0, o_done_valid);
    if (o_scl !== 1'b1)
      report_mismatch("scl idle level", 1, o_scl);
    for (int i = 0; i < pat_ccc.size(); i++)
      run_test(i);
    if (dones != accepts)
    begin
      errors++;
      $display("%0d done pulses for %0d accepted requests", dones, accepts);
    end
    if (UUT.u_chk.fails != 0)
    begin
      errors += UUT.u_chk.fails;
      $display("%0d bus or handshake assertions failed", UUT.u_chk.fails);
    end
    finish_run();
  end

endmodule

`default_nettype wire
